// ==== breakout_params.svh ====
`ifndef BREAKOUT_PARAMS_SVH
`define BREAKOUT_PARAMS_SVH

`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33

`define COORD_W 10
`define COLOR_W 10

`define BORDER 10
`define PADDLE_W 80
`define PADDLE_H 10
`define PADDLE_Y 450
`define PADDLE_STEP 2
`define BALL_R 7
`define BALL_SPEED 2
`define LIVES_INIT 3

`define KEY_ENTER 8'h5A
`define KEY_BKSP 8'h66
`define KEY_LEFT 8'h1C
`define KEY_RIGHT 8'h23

`define STEP_PERIOD_DEFAULT 200000

`endif

// ==== breakout_pkg.sv ====
`include "breakout_params.svh"

package breakout_pkg;

	typedef struct packed {
		logic [`COORD_W-1:0] x;
		logic [`COORD_W-1:0] y;
	} pixel_pos_t;

	typedef struct packed {
		logic hsync; // Active low
		logic vsync; // Active low
		logic blank_n;
	} vga_sync_t;

	typedef struct packed {
		logic [`COLOR_W-1:0] r;
		logic [`COLOR_W-1:0] g;
		logic [`COLOR_W-1:0] b;
	} rgb_t;

	typedef struct packed {
		logic signed [10:0] x; // Ball centre
		logic signed [10:0] y;
		logic signed [2:0] dx; // Pixels per step
		logic signed [2:0] dy;
	} ball_state_t;

	typedef enum logic [2:0] {
		CMD_NONE,
		CMD_START,
		CMD_RESTART,
		CMD_LEFT,
		CMD_RIGHT
	} key_cmd_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PLAY,
		ST_OVER
	} game_state_t;

endpackage

// ==== vga_timing.sv ====
`timescale 1ns/1ps
`include "breakout_params.svh"

module vga_timing (
	input logic VGA_clk,
	input logic reset,
	output breakout_pkg::pixel_pos_t pos,
	output breakout_pkg::vga_sync_t sync
);

	localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK; // 800
	localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK; // 525
	localparam int H_SYNC_START = `H_ACTIVE + `H_FRONT;
	localparam int V_SYNC_START = `V_ACTIVE + `V_FRONT;

	logic [`COORD_W-1:0] h_next;
	logic [`COORD_W-1:0] v_next;

	// Next raster position, so sync decodes line up with the counters
	always_comb
	begin
		h_next = pos.x + 1'b1;
		v_next = pos.y;
		if (pos.x == H_TOTAL - 1)
		begin
			h_next = '0;
			if (pos.y == V_TOTAL - 1)
				v_next = '0; // Frame wrap
			else
				v_next = pos.y + 1'b1;
		end
	end

	always_ff @(posedge VGA_clk)
	begin
		if (reset)
		begin
			pos <= '0;
			sync.hsync <= 1'b1;
			sync.vsync <= 1'b1;
			sync.blank_n <= 1'b1; // Pixel (0,0) is active
		end
		else
		begin
			pos.x <= h_next;
			pos.y <= v_next;
			sync.hsync <= !((h_next >= H_SYNC_START) && (h_next < H_SYNC_START + `H_SYNC));
			sync.vsync <= !((v_next >= V_SYNC_START) && (v_next < V_SYNC_START + `V_SYNC));
			sync.blank_n <= (h_next < `H_ACTIVE) && (v_next < `V_ACTIVE);
		end
	end

endmodule

// ==== key_decoder.sv ====
`timescale 1ns/1ps
`include "breakout_params.svh"

module key_decoder (
	input logic VGA_clk,
	input logic reset,
	input logic [7:0] scan_code,
	input logic key_strobe,
	input logic serve,
	output breakout_pkg::key_cmd_t cmd
);

	// Last recognised key stays in force until replaced or served
	always_ff @(posedge VGA_clk)
	begin
		if (reset || serve)
			cmd <= breakout_pkg::CMD_NONE;
		else if (key_strobe)
		begin
			case (scan_code)
				`KEY_ENTER: cmd <= breakout_pkg::CMD_START;
				`KEY_BKSP: cmd <= breakout_pkg::CMD_RESTART;
				`KEY_LEFT: cmd <= breakout_pkg::CMD_LEFT; // a
				`KEY_RIGHT: cmd <= breakout_pkg::CMD_RIGHT; // d
				default: cmd <= cmd; // Unknown codes ignored
			endcase
		end
	end

endmodule

// ==== game_control.sv ====
`timescale 1ns/1ps
`include "breakout_params.svh"

module game_control #(
	parameter int step_period = `STEP_PERIOD_DEFAULT
) (
	input logic VGA_clk,
	input logic reset,
	input breakout_pkg::key_cmd_t cmd,
	input logic miss,
	output logic step,
	output logic serve,
	output breakout_pkg::game_state_t state,
	output logic [1:0] lives
);

	localparam int CNT_W = $clog2(step_period + 1);

	logic [CNT_W-1:0] step_cnt;
	logic step_wrap;

	assign step_wrap = (step_cnt == step_period - 1);

	// Free-running divider, the strobe only leaves while playing
	always_ff @(posedge VGA_clk)
	begin
		if (reset)
		begin
			step_cnt <= '0;
			step <= 1'b0;
		end
		else
		begin
			step_cnt <= step_wrap ? '0 : step_cnt + 1'b1;
			step <= step_wrap && (state == breakout_pkg::ST_PLAY);
		end
	end

	always_ff @(posedge VGA_clk)
	begin
		if (reset)
		begin
			state <= breakout_pkg::ST_IDLE;
			lives <= 2'(`LIVES_INIT);
			serve <= 1'b0;
		end
		else
		begin
			serve <= 1'b0;
			// Command is still held while serve clears it
			if (cmd == breakout_pkg::CMD_RESTART && !serve)
			begin
				state <= breakout_pkg::ST_IDLE;
				lives <= 2'(`LIVES_INIT);
				serve <= 1'b1;
			end
			else
			begin
				case (state)
					breakout_pkg::ST_IDLE:
						if (cmd == breakout_pkg::CMD_START)
							state <= breakout_pkg::ST_PLAY;
					breakout_pkg::ST_PLAY:
						if (miss)
						begin
							if (lives != 2'd0)
							begin
								lives <= lives - 2'd1;
								serve <= 1'b1; // Re-serve one cycle after miss
							end
							else
								state <= breakout_pkg::ST_OVER;
						end
					breakout_pkg::ST_OVER: state <= breakout_pkg::ST_OVER; // Wait for backspace
					default: state <= breakout_pkg::ST_IDLE;
				endcase
			end
		end
	end

endmodule

// ==== paddle_control.sv ====
`timescale 1ns/1ps
`include "breakout_params.svh"

module paddle_control (
	input logic VGA_clk,
	input logic reset,
	input logic step,
	input logic serve,
	input breakout_pkg::key_cmd_t cmd,
	output logic [`COORD_W-1:0] paddle_x
);

	localparam int X_MIN = `BORDER + 1; // 11
	localparam int X_MAX = `H_ACTIVE - `BORDER - 1 - `PADDLE_W; // 549
	localparam int X_HOME = (`H_ACTIVE / 2) - (`PADDLE_W / 2); // 280

	always_ff @(posedge VGA_clk)
	begin
		if (reset || serve)
			paddle_x <= `COORD_W'(X_HOME);
		else if (step)
		begin
			if (cmd == breakout_pkg::CMD_LEFT)
			begin
				if (paddle_x < X_MIN + `PADDLE_STEP)
					paddle_x <= `COORD_W'(X_MIN); // Clamp at left border
				else
					paddle_x <= paddle_x - `COORD_W'(`PADDLE_STEP);
			end
			else if (cmd == breakout_pkg::CMD_RIGHT)
			begin
				if (paddle_x + `PADDLE_STEP > X_MAX)
					paddle_x <= `COORD_W'(X_MAX); // Clamp at right border
				else
					paddle_x <= paddle_x + `COORD_W'(`PADDLE_STEP);
			end
		end
	end

endmodule

// ==== ball_physics.sv ====
`timescale 1ns/1ps
`include "breakout_params.svh"

module ball_physics (
	input logic VGA_clk,
	input logic reset,
	input logic step,
	input logic serve,
	input logic [`COORD_W-1:0] paddle_x,
	output breakout_pkg::ball_state_t ball,
	output logic miss
);

	localparam breakout_pkg::ball_state_t BALL_SERVE = '{
		x: 11'(`H_ACTIVE / 2),
		y: 11'(`PADDLE_Y - `BALL_R),
		dx: 3'sd0,
		dy: 3'(`BALL_SPEED)
	};

	logic signed [10:0] px;
	logic hit_side_wall;
	logic hit_bottom;
	logic hit_top;
	logic hit_pad_top;
	logic hit_pad_side;
	logic take_miss;
	logic held; // Ball parked after a miss
	breakout_pkg::ball_state_t bounced;
	breakout_pkg::ball_state_t moved;

	assign px = $signed({1'b0, paddle_x});

	always_comb
	begin
		hit_side_wall = (ball.x + `BALL_R == `H_ACTIVE - `BORDER)
			|| (ball.x - `BALL_R == `BORDER);
		hit_bottom = (ball.y + `BALL_R == `V_ACTIVE);
		hit_top = (ball.y - `BALL_R == `BORDER);
		hit_pad_top = (ball.y + `BALL_R == `PADDLE_Y)
			&& (ball.x >= px) && (ball.x <= px + `PADDLE_W);
		hit_pad_side = (ball.y >= `PADDLE_Y) && (ball.y <= `PADDLE_Y + `PADDLE_H)
			&& ((ball.x + `BALL_R == px) || (ball.x - `BALL_R == px + `PADDLE_W));
		take_miss = hit_bottom && !hit_side_wall;

		// First matching case wins, bottom never coincides with the later ones
		bounced = ball;
		if (hit_side_wall)
			bounced.dx = -ball.dx;
		else if (hit_top)
			bounced.dy = -ball.dy;
		else if (hit_pad_top)
		begin
			bounced.dy = -ball.dy;
			if (ball.x < px + (3 * `PADDLE_W) / 8)
			begin
				if (ball.dx == 3'sd0)
					bounced.dx = -3'sd1; // Left zone
			end
			else if (ball.x < px + (5 * `PADDLE_W) / 8)
				bounced.dx = 3'sd0; // Centre sends it straight up
			else if (ball.x < px + `PADDLE_W)
			begin
				if (ball.dx == 3'sd0)
					bounced.dx = 3'sd1; // Right zone
			end
		end
		else if (hit_pad_side)
			bounced.dx = -ball.dx;

		moved = bounced;
		moved.x = ball.x + {{8{bounced.dx[2]}}, bounced.dx};
		moved.y = ball.y + {{8{bounced.dy[2]}}, bounced.dy};
	end

	always_ff @(posedge VGA_clk)
	begin
		if (reset || serve)
		begin
			ball <= BALL_SERVE;
			held <= 1'b0;
			miss <= 1'b0;
		end
		else
		begin
			miss <= 1'b0;
			if (step && !held)
			begin
				if (take_miss)
				begin
					miss <= 1'b1;
					held <= 1'b1;
				end
				else
					ball <= moved;
			end
		end
	end

endmodule

// ==== pixel_renderer.sv ====
`timescale 1ns/1ps
`include "breakout_params.svh"

module pixel_renderer (
	input logic VGA_clk,
	input logic reset,
	input breakout_pkg::pixel_pos_t pos,
	input breakout_pkg::vga_sync_t sync,
	input logic [`COORD_W-1:0] paddle_x,
	input breakout_pkg::ball_state_t ball,
	output breakout_pkg::rgb_t rgb,
	output breakout_pkg::vga_sync_t sync_out
);

	logic signed [10:0] ddx;
	logic signed [10:0] ddy;
	logic [21:0] sq_x;
	logic [21:0] sq_y;
	logic [22:0] dist_sq;
	logic is_border;
	logic is_ball;
	logic is_paddle;

	always_comb
	begin
		is_border = (pos.x <= `BORDER) || (pos.x >= `H_ACTIVE - `BORDER) || (pos.y <= `BORDER);

		// Disc test against the ball centre
		ddx = $signed({1'b0, pos.x}) - ball.x;
		ddy = $signed({1'b0, pos.y}) - ball.y;
		sq_x = ddx * ddx;
		sq_y = ddy * ddy;
		dist_sq = sq_x + sq_y;
		is_ball = (dist_sq < `BALL_R * `BALL_R);

		is_paddle = (pos.x > paddle_x) && (pos.x < paddle_x + `PADDLE_W)
			&& (pos.y >= `PADDLE_Y) && (pos.y <= `PADDLE_Y + `PADDLE_H);
	end

	// Colour and sync leave on the same edge
	always_ff @(posedge VGA_clk)
	begin
		if (reset)
		begin
			rgb <= '0;
			sync_out.hsync <= 1'b1;
			sync_out.vsync <= 1'b1;
			sync_out.blank_n <= 1'b0;
		end
		else
		begin
			rgb.r <= {`COLOR_W{is_border && sync.blank_n}};
			rgb.g <= {`COLOR_W{is_ball && sync.blank_n}};
			rgb.b <= {`COLOR_W{is_paddle && sync.blank_n}};
			sync_out <= sync;
		end
	end

endmodule

// ==== breakout_top.sv ====
`timescale 1ns/1ps
`include "breakout_params.svh"

module breakout_top #(
	parameter int step_period = `STEP_PERIOD_DEFAULT
) (
	input logic VGA_clk,
	input logic reset,
	input logic [7:0] scan_code,
	input logic key_strobe,
	output logic [`COLOR_W-1:0] VGA_R,
	output logic [`COLOR_W-1:0] VGA_G,
	output logic [`COLOR_W-1:0] VGA_B,
	output logic VGA_hSync,
	output logic VGA_vSync,
	output logic blank_n,
	output logic [1:0] lives,
	output breakout_pkg::game_state_t game_state
);

	breakout_pkg::pixel_pos_t pos;
	breakout_pkg::vga_sync_t sync;
	breakout_pkg::vga_sync_t sync_out;
	breakout_pkg::rgb_t rgb;
	breakout_pkg::key_cmd_t cmd;
	breakout_pkg::ball_state_t ball;
	logic [`COORD_W-1:0] paddle_x;
	logic step;
	logic serve;
	logic miss;

	vga_timing u_vga_timing (.VGA_clk, .reset, .pos, .sync);

	key_decoder u_key_decoder (.VGA_clk, .reset, .scan_code, .key_strobe, .serve, .cmd);

	game_control #(
		.step_period(step_period)
	) u_game_control (
		.VGA_clk, .reset, .cmd, .miss, .step, .serve, .state(game_state), .lives
	);

	paddle_control u_paddle_control (.VGA_clk, .reset, .step, .serve, .cmd, .paddle_x);

	ball_physics u_ball_physics (.VGA_clk, .reset, .step, .serve, .paddle_x, .ball, .miss);

	pixel_renderer u_pixel_renderer (
		.VGA_clk, .reset, .pos, .sync, .paddle_x, .ball, .rgb, .sync_out
	);

	assign VGA_R = rgb.r;
	assign VGA_G = rgb.g;
	assign VGA_B = rgb.b;
	assign VGA_hSync = sync_out.hsync;
	assign VGA_vSync = sync_out.vsync;
	assign blank_n = sync_out.blank_n;

endmodule

// ==== breakout_tb.sv ====
`timescale 1ns/1ps
`include "breakout_params.svh"

module breakout_tb;

	localparam int CLK_PERIOD = 8;
	localparam int STEP_PERIOD = 20;
	localparam int LINE_CYCLES = 800;
	localparam int FRAME_CYCLES = LINE_CYCLES * 525;
	localparam int TEST_CYCLES = 3 * FRAME_CYCLES; // Longest path waits out about three frames
	localparam logic [`COLOR_W-1:0] FULL = '1;
	localparam logic [31:0] RED = 32'(FULL) << (2 * `COLOR_W);
	localparam logic [31:0] GREEN = 32'(FULL) << `COLOR_W;
	localparam logic [31:0] BLUE = 32'(FULL);

	logic VGA_clk;
	logic reset;
	logic [7:0] scan_code;
	logic key_strobe;
	logic [`COLOR_W-1:0] VGA_R;
	logic [`COLOR_W-1:0] VGA_G;
	logic [`COLOR_W-1:0] VGA_B;
	logic VGA_hSync;
	logic VGA_vSync;
	logic blank_n;
	logic [1:0] lives;
	breakout_pkg::game_state_t game_state;

	int errors = 0;
	int checks = 0;

	// Pixel record lags the outputs by one cycle
	int pix_x = 0;
	int pix_line = -100000; // Unknown until the first vsync
	logic pix_valid = 1'b0;
	logic [31:0] pix_rgb = '0;

	logic prev_hsync;
	logic prev_vsync;
	logic prev_blank;
	logic h_seen;
	logic v_seen;
	int h_period;
	int h_low;
	int v_period;
	int v_low;
	int blank_len;

	breakout_top #(
		.step_period(STEP_PERIOD)
	) DUT (
		.VGA_clk, .reset, .scan_code, .key_strobe, .VGA_R, .VGA_G, .VGA_B,
		.VGA_hSync, .VGA_vSync, .blank_n, .lives, .game_state
	);

	initial
	begin
		VGA_clk = 1'b0;
		forever #(CLK_PERIOD / 2) VGA_clk = ~VGA_clk;
	end

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		errors++;
		$display("error %s expected %0h actual %0h", name, expected, actual);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else
			report_mismatch(name, expected, actual);
	endtask

	task automatic send_key(input logic [7:0] code);
		scan_code = code;
		key_strobe = 1'b1;
		@(negedge VGA_clk);
		key_strobe = 1'b0;
		scan_code = 8'h00;
	endtask

	task automatic wait_state(input breakout_pkg::game_state_t target, input int limit,
		input string name);
		int n;
		n = 0;
		while (game_state != target && n < limit)
		begin
			@(negedge VGA_clk);
			n++;
		end
		check_value(name, target, game_state);
	endtask

	task automatic wait_lives(input logic [1:0] target, input int limit, input string name);
		int n;
		n = 0;
		while (lives != target && n < limit)
		begin
			@(negedge VGA_clk);
			n++;
		end
		check_value(name, target, lives);
	endtask

	task automatic wait_pixel(input int x, input int y, input int limit, input string name);
		int n;
		n = 0;
		while (!(pix_valid && pix_x == x && pix_line == y) && n < limit)
		begin
			@(negedge VGA_clk);
			n++;
		end
		if (n >= limit)
		begin
			errors++;
			$display("%s: pixel %0d of line %0d never reached the display", name, x, y);
		end
	endtask

	// Raster monitor and pixel record
	always @(negedge VGA_clk)
	begin
		if (reset)
		begin
			prev_hsync = 1'b1;
			prev_vsync = 1'b1;
			prev_blank = 1'b0;
			h_seen = 1'b0;
			v_seen = 1'b0;
			pix_valid <= 1'b0;
		end
		else
		begin
			if (!VGA_hSync && prev_hsync)
			begin
				if (h_seen)
					check_value("hsync_period", LINE_CYCLES, h_period);
				h_seen = 1'b1;
				h_period = 1;
			end
			else
				h_period++;
			if (!VGA_hSync)
				h_low = prev_hsync ? 1 : h_low + 1;
			else if (!prev_hsync && h_seen)
				check_value("hsync_width", 96, h_low);

			if (!VGA_vSync && prev_vsync)
			begin
				if (v_seen)
					check_value("frame_length", FRAME_CYCLES, v_period);
				v_seen = 1'b1;
				v_period = 1;
			end
			else
				v_period++;
			if (!VGA_vSync)
				v_low = prev_vsync ? 1 : v_low + 1;
			else if (!prev_vsync && v_seen)
				check_value("vsync_width", 2 * LINE_CYCLES, v_low);

			if (blank_n)
				blank_len = prev_blank ? blank_len + 1 : 1;
			else if (prev_blank)
				check_value("active_width", 640, blank_len);

			if (!VGA_vSync && prev_vsync)
				pix_line <= -1;
			else if (blank_n && !prev_blank)
				pix_line <= pix_line + 1; // New visible line
			if (blank_n && !prev_blank)
				pix_x <= 0;
			else if (blank_n)
				pix_x <= pix_x + 1;
			pix_valid <= blank_n;
			pix_rgb <= {2'b00, VGA_R, VGA_G, VGA_B};

			prev_hsync = VGA_hSync;
			prev_vsync = VGA_vSync;
			prev_blank = blank_n;
		end
	end

	blanking_zero: assert property (@(negedge VGA_clk) disable iff (reset)
		!blank_n |-> (VGA_R == '0 && VGA_G == '0 && VGA_B == '0))
	else
	begin
		errors++;
		$display("error blanking expected 0 actual %h", {VGA_R, VGA_G, VGA_B});
	end

	initial
	begin
		#(2.0 * TEST_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("checks %0d errors %0d", checks, errors);
		$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		int seed;
		int idle_cycles;
		seed = 69139;
		reset = 1'b1;
		scan_code = 8'h00;
		key_strobe = 1'b0;
		repeat (5) @(negedge VGA_clk);
		reset = 1'b0;
		@(negedge VGA_clk);
		check_value("reset_state", breakout_pkg::ST_IDLE, game_state);
		check_value("reset_lives", 3, lives);
		idle_cycles = 50 + ($unsigned($random(seed)) % 200);
		repeat (idle_cycles) @(negedge VGA_clk);

		// Idle frame contents
		wait_pixel(0, 0, FRAME_CYCLES + LINE_CYCLES, "idle_line0");
		for (int i = 0; i < 640; i++)
		begin
			check_value("idle_line0", RED, pix_rgb);
			@(negedge VGA_clk);
		end
		wait_pixel(320, 443, FRAME_CYCLES, "idle_ball");
		check_value("idle_ball", GREEN, pix_rgb);
		wait_pixel(281, 455, FRAME_CYCLES, "idle_paddle");
		for (int i = 281; i <= 359; i++)
		begin
			check_value("idle_paddle", BLUE, pix_rgb);
			@(negedge VGA_clk);
		end

		// Start and a rally straight off the paddle centre
		send_key(`KEY_ENTER);
		wait_state(breakout_pkg::ST_PLAY, 10, "start_state");
		repeat (1000 * STEP_PERIOD) @(negedge VGA_clk);
		check_value("rally_lives", 3, lives);
		check_value("rally_state", breakout_pkg::ST_PLAY, game_state);

		// Paddle runs away left so every serve is missed
		send_key(`KEY_LEFT);
		for (int k = 2; k >= 0; k--)
		begin
			wait_lives(2'(k), 2000 * STEP_PERIOD, "miss_lives");
			check_value("miss_state", breakout_pkg::ST_PLAY, game_state);
			@(negedge VGA_clk); // Let serve clear the held key first
			send_key(`KEY_LEFT);
		end
		wait_state(breakout_pkg::ST_OVER, 2000 * STEP_PERIOD, "over_state");
		check_value("over_lives", 0, lives);

		send_key(`KEY_BKSP);
		wait_state(breakout_pkg::ST_IDLE, 10, "restart_state");
		check_value("restart_lives", 3, lives);

		// Serve near line 450 so the ball is still high when line 455 is drawn
		wait_pixel(0, 450, FRAME_CYCLES + LINE_CYCLES, "clamp_sync");
		send_key(`KEY_ENTER);
		wait_state(breakout_pkg::ST_PLAY, 10, "clamp_state");
		send_key(`KEY_RIGHT);
		wait_pixel(628, 455, 10 * LINE_CYCLES, "clamp_inside");
		check_value("clamp_inside", BLUE, pix_rgb);
		@(negedge VGA_clk);
		check_value("clamp_outside", 0, pix_rgb);

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== breakout.f ====
+incdir+.
breakout_pkg.sv
vga_timing.sv
key_decoder.sv
game_control.sv
paddle_control.sv
ball_physics.sv
pixel_renderer.sv
breakout_top.sv
breakout_tb.sv

// ==== Bender.yml ====
package:
  name: breakout

export_include_dirs:
  - .

sources:
  - breakout_pkg.sv
  - vga_timing.sv
  - key_decoder.sv
  - game_control.sv
  - paddle_control.sv
  - ball_physics.sv
  - pixel_renderer.sv
  - breakout_top.sv
  - target: test
    files:
      - breakout_tb.sv
